// ==== hw/paillier_pkg.sv ====
package paillier_pkg;

  // Word size of all modular arithmetic
  localparam int word_width = 32;

  // Public key, n = 251 * 241
  localparam logic [15:0] n_value = 16'd60491;

  // All arithmetic is done modulo n squared, which fits in one word
  localparam logic [31:0] n_squared = 32'd3659161081;

  localparam int n_bits = 16;           // Exponent bits scanned in n
  localparam int candidate_count = 10;  // Digits '0' to '9'

  // Design LFSR reset state
  localparam logic [15:0] lfsr_seed = 16'hACE1;

  typedef logic [word_width-1:0] word_t;

  // Candidate number taken from one ASCII digit
  typedef logic [3:0] vote_t;

  typedef word_t cipher_t;  // Same size as an arithmetic word

endpackage

// ==== hw/modmul_if.sv ====
`timescale 1ns/10ps

interface modmul_if import paillier_pkg::*;
  ();

  logic  req_valid;
  logic  req_ready;
  word_t a;
  word_t b;

  // Response is a one-cycle pulse with no back-pressure
  logic  rsp_valid;
  word_t product;

  modport requester (
    output req_valid, a, b,
    input  req_ready, rsp_valid, product
  );

  modport multiplier (
    input  req_valid, a, b,
    output req_ready, rsp_valid, product
  );

endinterface

// ==== hw/vote_processor.sv ====
`timescale 1ns/10ps

module vote_processor import paillier_pkg::*; (
  input  logic       clk_100mhz,
  input  logic       sys_rst,
  input  logic [7:0] byte_data,
  input  logic       byte_valid,
  output logic       byte_ready,
  output vote_t      vote,
  output logic       vote_valid,
  input  logic       vote_ready
);

  logic [7:0] digit;
  logic       is_digit;

  // Bytes below '0' wrap to large values and fail the range check
  assign digit = byte_data - 8'h30;
  assign is_digit = (digit < candidate_count);

  // Output register can take a byte when empty or being drained
  assign byte_ready = !vote_valid || vote_ready;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      vote_valid <= 1'b0;
    end else if (byte_ready) begin
      vote_valid <= byte_valid && is_digit;  // Other bytes are absorbed
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (byte_valid && byte_ready && is_digit) begin
      vote <= digit[3:0];
    end
  end

endmodule

// ==== hw/elastic_buffer.sv ====
`timescale 1ns/10ps

module elastic_buffer #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_100mhz,
  input  logic     sys_rst,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t   mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;  // Entries held, 0 to 2
  logic       push;
  logic       pop;

  assign in_ready = (count != 2'd2);
  assign out_valid = (count != 2'd0);
  assign out_data = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      count <= count + {1'b0, push} - {1'b0, pop};  // Push and pop may coincide
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

// ==== hw/rng_lfsr.sv ====
`timescale 1ns/10ps

module rng_lfsr import paillier_pkg::*; (
  input  logic  clk_100mhz,
  input  logic  sys_rst,
  input  logic  step,
  output word_t value
);

  logic [15:0] state;
  logic        feedback;
  logic [15:0] reduced;

  // Taps 16, 14, 13, 11
  assign feedback = state[15] ^ state[13] ^ state[12] ^ state[10];

  // State is below 2n, one subtraction brings it under n
  assign reduced = (state < n_value) ? state : state - n_value;
  assign value = word_t'(reduced);

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= lfsr_seed;
    end else if (step) begin
      state <= {state[14:0], feedback};
    end
  end

endmodule

// ==== hw/mod_multiplier.sv ====
`timescale 1ns/10ps

module mod_multiplier import paillier_pkg::*; (
  input logic          clk_100mhz,
  input logic          sys_rst,
  modmul_if.multiplier mul
);

  typedef enum logic [1:0] {mul_idle, mul_load, mul_run} mul_state_t;

  mul_state_t state;
  word_t      a_reg;
  word_t      b_reg;   // Shifted left, MSB is the current bit
  word_t      acc;
  logic [4:0] bit_count;

  // One extra bit for the intermediate sums
  logic [word_width:0] doubled;
  logic [word_width:0] doubled_red;
  logic [word_width:0] summed;
  logic [word_width:0] summed_red;

  assign mul.req_ready = (state == mul_idle);
  assign mul.product = acc;

  // Double, reduce, conditionally add a, reduce again
  always_comb begin
    doubled = {acc, 1'b0};
    if (doubled >= {1'b0, n_squared}) begin
      doubled_red = doubled - {1'b0, n_squared};
    end else begin
      doubled_red = doubled;
    end
    summed = doubled_red + (b_reg[word_width-1] ? {1'b0, a_reg} : '0);
    if (summed >= {1'b0, n_squared}) begin
      summed_red = summed - {1'b0, n_squared};
    end else begin
      summed_red = summed;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= mul_idle;
      bit_count <= '0;
      mul.rsp_valid <= 1'b0;
    end else begin
      mul.rsp_valid <= 1'b0;
      case (state)
        mul_idle: if (mul.req_valid) state <= mul_load;
        mul_load: begin
          bit_count <= '0;
          state <= mul_run;
        end
        mul_run: begin
          bit_count <= bit_count + 5'd1;
          if (bit_count == 5'd31) begin  // Last of 32 iterations
            state <= mul_idle;
            mul.rsp_valid <= 1'b1;
          end
        end
        default: state <= mul_idle;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (state == mul_idle && mul.req_valid) begin
      a_reg <= mul.a;
      b_reg <= mul.b;
    end else if (state == mul_load) begin
      // One subtraction is enough since any word is below 2 * n squared
      if (a_reg >= n_squared) a_reg <= a_reg - n_squared;
      acc <= '0;
    end else if (state == mul_run) begin
      acc <= summed_red[word_width-1:0];
      b_reg <= b_reg << 1;
    end
  end

endmodule

// ==== hw/mod_exponentiator.sv ====
`timescale 1ns/10ps

module mod_exponentiator import paillier_pkg::*; (
  input  logic  clk_100mhz,
  input  logic  sys_rst,
  input  word_t base,
  input  logic  start_valid,
  output logic  start_ready,
  output logic  done_valid,
  output word_t result,
  input  logic  done_ready
);

  typedef enum logic [1:0] {exp_idle, exp_issue, exp_wait, exp_done} exp_state_t;
  typedef logic [$clog2(n_bits)-1:0] bit_idx_t;

  exp_state_t state;
  bit_idx_t   bit_idx;     // Exponent bit being processed
  logic       mult_step;   // High while multiplying by the base
  word_t      base_reg;
  word_t      acc;

  modmul_if mm_bus ();

  mod_multiplier u_mul (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .mul        (mm_bus.multiplier)
  );

  assign start_ready = (state == exp_idle);
  assign done_valid = (state == exp_done);
  assign result = acc;

  // Square uses acc twice, multiply uses the base
  assign mm_bus.req_valid = (state == exp_issue);
  assign mm_bus.a = acc;
  assign mm_bus.b = mult_step ? base_reg : acc;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= exp_idle;
      bit_idx <= '0;
      mult_step <= 1'b0;
    end else begin
      case (state)
        exp_idle: begin
          if (start_valid) begin
            bit_idx <= bit_idx_t'(n_bits - 1);  // Left to right, MSB first
            mult_step <= 1'b0;
            state <= exp_issue;
          end
        end
        exp_issue: if (mm_bus.req_ready) state <= exp_wait;
        exp_wait: begin
          if (mm_bus.rsp_valid) begin
            if (!mult_step && n_value[bit_idx]) begin
              mult_step <= 1'b1;  // Set bit, multiply after the squaring
              state <= exp_issue;
            end else begin
              mult_step <= 1'b0;
              if (bit_idx == '0) begin
                state <= exp_done;
              end else begin
                bit_idx <= bit_idx - 1'b1;
                state <= exp_issue;
              end
            end
          end
        end
        exp_done: if (done_ready) state <= exp_idle;
        default: state <= exp_idle;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (state == exp_idle && start_valid) begin
      base_reg <= base;
      acc <= word_t'(1);
    end else if (state == exp_wait && mm_bus.rsp_valid) begin
      acc <= mm_bus.product;
    end
  end

endmodule

// ==== hw/candidate_encryptor.sv ====
`timescale 1ns/10ps

module candidate_encryptor import paillier_pkg::*; (
  input  logic    clk_100mhz,
  input  logic    sys_rst,
  input  vote_t   vote,
  input  logic    vote_valid,
  output logic    vote_ready,
  output cipher_t cipher,
  output logic    cipher_valid,
  input  logic    cipher_ready
);

  typedef enum logic [2:0] {
    enc_idle, enc_start, enc_expo, enc_mult, enc_wait, enc_hold
  } enc_state_t;

  enc_state_t state;
  logic       lfsr_step;
  word_t      r_value;
  logic       expo_start_ready;
  logic       expo_done_valid;
  word_t      rn_result;
  word_t      rn_reg;     // r^n mod n^2
  word_t      plain_reg;  // 1 + m*n
  cipher_t    cipher_reg;

  modmul_if final_mul ();

  rng_lfsr u_rng (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .step       (lfsr_step),
    .value      (r_value)
  );

  mod_exponentiator u_expo (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .base        (r_value),
    .start_valid (state == enc_start),
    .start_ready (expo_start_ready),
    .done_valid  (expo_done_valid),
    .result      (rn_result),
    .done_ready  (state == enc_expo)
  );

  mod_multiplier u_final_mul (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .mul        (final_mul.multiplier)
  );

  assign vote_ready = (state == enc_idle);
  assign lfsr_step = vote_valid && vote_ready;  // Fresh r for each vote
  assign cipher_valid = (state == enc_hold);
  assign cipher = cipher_reg;

  assign final_mul.req_valid = (state == enc_mult);
  assign final_mul.a = rn_reg;
  assign final_mul.b = plain_reg;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= enc_idle;
    end else begin
      case (state)
        enc_idle: if (vote_valid) state <= enc_start;
        enc_start: if (expo_start_ready) state <= enc_expo;
        enc_expo: if (expo_done_valid) state <= enc_mult;
        enc_mult: if (final_mul.req_ready) state <= enc_wait;
        enc_wait: if (final_mul.rsp_valid) state <= enc_hold;
        enc_hold: if (cipher_ready) state <= enc_idle;
        default: state <= enc_idle;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    // m*n + 1 stays below n^2, no reduction
    if (lfsr_step) plain_reg <= word_t'(vote) * word_t'(n_value) + word_t'(1);
    if (state == enc_expo && expo_done_valid) rn_reg <= rn_result;
    if (state == enc_wait && final_mul.rsp_valid) cipher_reg <= final_mul.product;
  end

endmodule

// ==== hw/vote_encryptor_top.sv ====
`timescale 1ns/10ps

module vote_encryptor_top import paillier_pkg::*; (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic [7:0]  vote_byte,
  input  logic        vote_valid,
  output logic        vote_ready,
  output logic [31:0] cipher_data,
  output logic        cipher_valid,
  input  logic        cipher_ready
);

  // Filtered votes
  vote_t   proc_vote;
  logic    proc_valid;
  logic    proc_ready;

  // Vote buffer to encryptor
  vote_t   buf_vote;
  logic    buf_vote_valid;
  logic    buf_vote_ready;

  // Encryptor to cipher buffer
  cipher_t enc_cipher;
  logic    enc_valid;
  logic    enc_ready;

  vote_processor u_vote_processor (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .byte_data  (vote_byte),
    .byte_valid (vote_valid),
    .byte_ready (vote_ready),
    .vote       (proc_vote),
    .vote_valid (proc_valid),
    .vote_ready (proc_ready)
  );

  elastic_buffer #(.payload_t(vote_t)) u_vote_buffer (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .in_data    (proc_vote),
    .in_valid   (proc_valid),
    .in_ready   (proc_ready),
    .out_data   (buf_vote),
    .out_valid  (buf_vote_valid),
    .out_ready  (buf_vote_ready)
  );

  candidate_encryptor u_encryptor (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .vote         (buf_vote),
    .vote_valid   (buf_vote_valid),
    .vote_ready   (buf_vote_ready),
    .cipher       (enc_cipher),
    .cipher_valid (enc_valid),
    .cipher_ready (enc_ready)
  );

  elastic_buffer #(.payload_t(cipher_t)) u_cipher_buffer (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .in_data    (enc_cipher),
    .in_valid   (enc_valid),
    .in_ready   (enc_ready),
    .out_data   (cipher_data),
    .out_valid  (cipher_valid),
    .out_ready  (cipher_ready)
  );

endmodule

// ==== verification/tb_vote_encryptor.sv ====
`timescale 1ns/10ps

module tb_vote_encryptor;

  localparam logic [15:0] model_n = 16'd60491;  // 251 * 241
  localparam logic [63:0] model_n2 = 64'd60491 * 64'd60491;
  localparam logic [15:0] model_seed = 16'hACE1;
  localparam int vote_budget = 1500;  // Generous cycles per vote
  localparam int timeout_cycles = 40 * vote_budget;

  logic        clk_100mhz;
  logic        sys_rst;
  logic [7:0]  vote_byte;
  logic        vote_valid;
  logic        vote_ready;
  logic [31:0] cipher_data;
  logic        cipher_valid;
  logic        cipher_ready;

  logic [31:0] expected_q[$];
  logic [15:0] model_lfsr;  // Mirror of the design LFSR
  logic [31:0] stim_lfsr;
  logic [31:0] bp_lfsr;     // Separate stream for cipher_ready
  logic        bp_enable;
  logic        burst_active;
  logic        saw_ready_low;
  logic        prev_stall;
  logic [31:0] prev_data;
  int          cycle_count;
  int          check_count;
  int          error_count;
  int          test_start_errors;

  // Neighbours of the digit range on both sides
  logic [7:0] mixed_bytes [12] = '{"7", "a", 8'h0d, "2", "Z", "/", ":", "0",
                                   8'h0a, "9", 8'hff, "5"};

  vote_encryptor_top dut0 (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .vote_byte    (vote_byte),
    .vote_valid   (vote_valid),
    .vote_ready   (vote_ready),
    .cipher_data  (cipher_data),
    .cipher_valid (cipher_valid),
    .cipher_ready (cipher_ready)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
  endfunction

  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    repeat (count) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      bits = {bits[30:0], stim_lfsr[0]};
    end
    return bits;
  endfunction

  function automatic logic [7:0] random_digit();
    return 8'h30 + 8'(rand_bits(8) % 10);
  endfunction

  // One encryption with g = n + 1 and r from the LFSR model
  function automatic logic [31:0] expected_cipher(input logic [7:0] digit_byte);
    logic [63:0] r;
    logic [63:0] acc;
    logic [63:0] plain;
    logic [15:0] exp_bits;
    model_lfsr = {model_lfsr[14:0],
                  model_lfsr[15] ^ model_lfsr[13] ^ model_lfsr[12] ^ model_lfsr[10]};
    r = 64'((model_lfsr < model_n) ? model_lfsr : model_lfsr - model_n);
    acc = 64'd1;
    exp_bits = model_n;
    repeat (16) begin
      acc = (acc * acc) % model_n2;
      if (exp_bits[15]) acc = (acc * r) % model_n2;
      exp_bits = exp_bits << 1;
    end
    plain = (64'(digit_byte) - 64'h30) * 64'(model_n) + 64'd1;
    return 32'((acc * plain) % model_n2);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] observed);
    check_count++;
    if (expected !== observed) begin
      $display("mismatch at %0t: %s expected %h observed %h", $time, name, expected, observed);
      error_count++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_100mhz);
    #1;
  endtask

  task automatic send_byte(input logic [7:0] b);
    vote_byte = b;
    vote_valid = 1'b1;
    if (b >= 8'h30 && b <= 8'h39) expected_q.push_back(expected_cipher(b));
    while (!vote_ready) next_cycle();
    next_cycle();  // Byte taken on this edge
    vote_valid = 1'b0;
  endtask

  task automatic send_gap();
    repeat (rand_bits(2)) next_cycle();
  endtask

  // Each outstanding ciphertext gets one vote budget
  task automatic wait_drained();
    int limit;
    int waited;
    limit = (expected_q.size() + 1) * vote_budget;
    waited = 0;
    while (expected_q.size() != 0 && waited < limit) begin
      next_cycle();
      waited++;
    end
    repeat (20) next_cycle();
  endtask

  task automatic end_test(input string name);
    $display("test %s finished with %0d errors", name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  // One new ready bit per cycle while back-pressure is on
  always @(posedge clk_100mhz) begin
    if (bp_enable) begin
      bp_lfsr = lfsr_next(bp_lfsr);
      #1 cipher_ready = bp_lfsr[0];
    end else begin
      #1 cipher_ready = 1'b1;
    end
  end

  // Mid-cycle values equal those at the next rising edge
  always @(negedge clk_100mhz) begin
    if (!sys_rst) begin
      if (prev_stall) begin  // Stalled output must not move
        check_value("cipher_valid", 32'd1, 32'(cipher_valid));
        check_value("cipher_data", prev_data, cipher_data);
      end
      if (cipher_valid && cipher_ready) begin
        if (expected_q.size() == 0) begin
          $display("ciphertext %h arrived at %0t with none expected", cipher_data, $time);
          error_count++;
        end else begin
          check_value("cipher_data", expected_q.pop_front(), cipher_data);
        end
      end
      if (burst_active && !vote_ready) saw_ready_low = 1'b1;
      prev_stall = cipher_valid && !cipher_ready;
      prev_data = cipher_data;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk_100mhz);
      cycle_count++;
    end
    $display("timeout after %0d cycles, %0d ciphertexts outstanding", cycle_count,
             expected_q.size());
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk_100mhz = 1'b0;
    sys_rst = 1'b1;
    vote_byte = 8'h00;
    vote_valid = 1'b0;
    cipher_ready = 1'b1;
    model_lfsr = model_seed;
    stim_lfsr = 32'h828a_cfb5;
    bp_lfsr = 32'h828a_cfb5;
    bp_enable = 1'b0;
    burst_active = 1'b0;
    saw_ready_low = 1'b0;
    prev_stall = 1'b0;
    prev_data = '0;
    check_count = 0;
    error_count = 0;
    test_start_errors = 0;
    repeat (10) @(posedge clk_100mhz);
    #1;
    sys_rst = 1'b0;
    next_cycle();

    check_value("cipher_valid", 32'd0, 32'(cipher_valid));
    check_value("vote_ready", 32'd1, 32'(vote_ready));
    end_test("after_reset");

    send_byte("3");
    wait_drained();
    end_test("single_vote");

    foreach (mixed_bytes[i]) begin
      send_byte(mixed_bytes[i]);
      send_gap();
    end
    repeat (6) begin  // Any byte value
      send_byte(8'(rand_bits(8)));
      send_gap();
    end
    wait_drained();
    end_test("mixed_bytes");

    burst_active = 1'b1;
    repeat (20) send_byte(random_digit());
    wait_drained();
    burst_active = 1'b0;
    if (!saw_ready_low) begin
      $display("vote_ready never went low during the burst of 20 digits");
      error_count++;
    end
    end_test("burst");

    bp_enable = 1'b1;
    repeat (10) begin
      send_byte(random_digit());
      send_gap();
    end
    wait_drained();
    bp_enable = 1'b0;
    end_test("back_pressure");

    repeat (vote_budget) next_cycle();  // Room for a stray output
    if (expected_q.size() != 0) begin
      $display("%0d expected ciphertexts never arrived", expected_q.size());
      error_count++;
    end
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
hw/paillier_pkg.sv
hw/modmul_if.sv
hw/vote_processor.sv
hw/elastic_buffer.sv
hw/rng_lfsr.sv
hw/mod_multiplier.sv
hw/mod_exponentiator.sv
hw/candidate_encryptor.sv
hw/vote_encryptor_top.sv
verification/tb_vote_encryptor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the result
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -f compile.f --top-module tb_vote_encryptor -o tb_vote_encryptor

sim_output=$(./obj_dir/tb_vote_encryptor)
echo "$sim_output"

if grep -qx "Simulation passed" <<< "$sim_output"; then
  exit 0
else
  exit 1
fi
